// ==== sources.f ====
design/alut_pkg.sv
design/alut_mem_if.sv
design/alut_mem.sv
design/alut_mem_arbiter.sv
design/alut_addr_checker.sv
design/alut_age_checker.sv
design/alut_top.sv
bench/alut_tb.sv

// ==== Makefile ====
# Verilator build and run for the alut testbench

VERILATOR ?= verilator
TOP       ?= alut_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/alut_tb.sv ====
// alut testbench, learns and looks up frames, checks the time counter and the invalidation sweeps
module alut_tb
   import alut_pkg::*;
();

   typedef enum logic [2:0] {op_frame, op_time, op_age_short, op_age_long,
                             op_inval_aged, op_inval_all} op_e;

   typedef struct packed
   {
      op_e               op;
      logic [mac_w-1:0]  src;
      logic [port_w-1:0] src_port;   // random per row
      logic [mac_w-1:0]  dst;
      logic              exp_fwd;    // 1 forwards to the learned port, 0 floods
   } row_t;

   localparam logic [time_w-1:0] age_long  = 32'd5000;   // longer than the whole run
   localparam logic [time_w-1:0] age_short = 32'd2;
   localparam int frame_limit = 100;                      // cycles per wait
   localparam int sweep_limit = 2000;

   // index = xor of the six bytes, all distinct here
   localparam logic [mac_w-1:0] mac_a = 48'h001a_2b00_0011;   // 0x20
   localparam logic [mac_w-1:0] mac_b = 48'h001a_2b00_0022;   // 0x13
   localparam logic [mac_w-1:0] mac_c = 48'h001a_2b00_00c4;   // 0xf5
   localparam logic [mac_w-1:0] mac_d = 48'h001a_2b00_0057;   // 0x66
   localparam logic [mac_w-1:0] mac_e = 48'h001a_2b00_00e8;   // 0xd9
   localparam logic [mac_w-1:0] mac_f = 48'h001a_2b00_0091;   // 0xa0
   localparam logic [mac_w-1:0] mac_g = 48'h001a_2b00_003a;   // 0x0b
   localparam logic [mac_w-1:0] mac_h = 48'h001a_2b00_00ce;   // 0xff

   logic              pclk20 = 1'b0;
   logic              n_p_reset20;
   age_cmd_e          command;
   logic [7:0]        div_clk;
   logic [time_w-1:0] best_bfr_age;
   logic              frame_valid;
   logic [mac_w-1:0]  src_mac;
   logic [port_w-1:0] src_port;
   logic [mac_w-1:0]  dst_mac;
   logic              fwd_valid;
   logic [port_w-1:0] fwd_port;
   logic              fwd_broadcast;
   logic [time_w-1:0] curr_time;
   logic [mac_w-1:0]  lst_inv_addr;
   logic [port_w-1:0] lst_inv_port;
   logic              inval_in_prog;
   logic              age_check_active;

   row_t              rows[$];
   bit                model_valid [256];   // bench copy of the table
   bit                model_old   [256];   // older than the short age
   logic [mac_w-1:0]  model_mac   [256];
   logic [port_w-1:0] model_port  [256];
   bit                short_age;
   int                value_errs;
   int                other_errs;
   bit                aborted;             // a wait timed out

   alut_top alut_top_inst (.*);

   always #4 pclk20 = ~pclk20;

   function automatic logic [addr_w-1:0] index_of(input logic [mac_w-1:0] mac);
      logic [mac_w-1:0]  rest;
      logic [addr_w-1:0] idx;
      rest = mac;
      idx  = '0;
      repeat (mac_w / 8)
      begin
         idx  = idx ^ rest[7:0];
         rest = rest >> 8;
      end
      return idx;
   endfunction

   // forwarded only if valid, same mac and not aged
   function automatic logic predict_fwd(input logic [mac_w-1:0] dst);
      logic [addr_w-1:0] idx;
      idx = index_of(dst);
      return model_valid[idx] && (model_mac[idx] == dst) && !(short_age && model_old[idx]);
   endfunction

   function automatic void add_row(input op_e op, input logic [mac_w-1:0] src,
                                   input logic [mac_w-1:0] dst, input logic exp_fwd);
      row_t r;
      r.op       = op;
      r.src      = src;
      r.src_port = port_w'($urandom % 4);
      r.dst      = dst;
      r.exp_fwd  = exp_fwd;
      rows.push_back(r);
   endfunction

   // ------------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------------
   task automatic check_fwd(input string name, input logic [port_w-1:0] exp_port,
                            input logic exp_flag, input logic [port_w-1:0] act_port,
                            input logic act_flag);
      if ((act_port !== exp_port) || (act_flag !== exp_flag))
      begin
         value_errs++;
         $display("** Error %s: expected port %0d flag %0b, actual port %0d flag %0b",
                  name, exp_port, exp_flag, act_port, act_flag);
      end
   endtask

   task automatic check_mac(input string name, input logic [mac_w-1:0] exp_mac,
                            input logic [mac_w-1:0] act_mac);
      if (act_mac !== exp_mac)
      begin
         value_errs++;
         $display("** Error %s: expected %h, actual %h", name, exp_mac, act_mac);
      end
   endtask

   task automatic check_time(input string name, input logic [time_w-1:0] exp_time,
                             input logic [time_w-1:0] act_time);
      if (act_time !== exp_time)
      begin
         value_errs++;
         $display("** Error %s: expected %0d, actual %0d", name, exp_time, act_time);
      end
   endtask

   // ------------------------------------------------------------------------
   // waits, each one bounded
   // ------------------------------------------------------------------------
   task automatic wait_fwd(input string name);
      int n;
      n = 0;
      @(negedge pclk20);
      while (!fwd_valid && (n < frame_limit))
      begin
         @(negedge pclk20);
         n++;
      end
      if (!fwd_valid)
      begin
         other_errs++;
         aborted = 1'b1;
         $display("%s: no forward result after %0d cycles", name, frame_limit);
      end
   endtask

   task automatic wait_active(input string name, input logic level, input int limit);
      int n;
      n = 0;
      @(negedge pclk20);
      while ((age_check_active !== level) && (n < limit))
      begin
         @(negedge pclk20);
         n++;
      end
      if (age_check_active !== level)
      begin
         other_errs++;
         aborted = 1'b1;
         $display("%s: age checker activity did not go to %0b in time", name, level);
      end
   endtask

   // ------------------------------------------------------------------------
   // row handling
   // ------------------------------------------------------------------------
   task automatic apply_frame(input row_t r, input string name);
      logic [addr_w-1:0] idx;
      @(posedge pclk20);
      src_mac     <= r.src;
      src_port    <= r.src_port;
      dst_mac     <= r.dst;
      frame_valid <= 1'b1;
      @(posedge pclk20);
      frame_valid <= 1'b0;                  // single cycle strobe
      wait_fwd(name);
      if (aborted)
         return;
      if (predict_fwd(r.dst) !== r.exp_fwd)
      begin
         other_errs++;
         $display("%s: table row and table model disagree on the destination", name);
      end
      idx = index_of(r.dst);
      check_fwd(name, r.exp_fwd ? model_port[idx] : '0, !r.exp_fwd, fwd_port, fwd_broadcast);
      idx = index_of(r.src);                // source learned after the lookup
      model_valid[idx] = 1'b1;
      model_old[idx]   = 1'b0;
      model_mac[idx]   = r.src;
      model_port[idx]  = r.src_port;
   endtask

   task automatic run_sweep(input age_cmd_e cmd, input string name);
      @(posedge pclk20);
      command <= cmd;
      wait_active(name, 1'b1, 20);
      if (aborted)
         return;
      @(posedge pclk20);
      command <= cmd_none;
      wait_active(name, 1'b0, sweep_limit);   // falls at the end of the sweep
   endtask

   task automatic apply_row(input row_t r, input int i);
      string             name;
      logic [time_w-1:0] t0;
      int                last;
      logic              exp_prog;
      name = $sformatf("row %0d %s", i, r.op.name());
      case (r.op)
         op_frame:
            apply_frame(r, name);
         op_time:
         begin
            @(negedge pclk20);
            t0 = curr_time;
            repeat (40) @(negedge pclk20);          // ten ticks at div_clk 3
            check_time(name, t0 + 32'd10, curr_time);
         end
         op_age_short:
         begin
            @(posedge pclk20);
            best_bfr_age <= age_short;
            repeat (20) @(posedge pclk20);           // five ticks or more
            short_age = 1'b1;
            foreach (model_old[k])
               model_old[k] = 1'b1;
         end
         op_age_long:
         begin
            @(posedge pclk20);
            best_bfr_age <= age_long;
            short_age = 1'b0;
         end
         op_inval_aged:
         begin
            run_sweep(cmd_inval_aged, name);
            last = -1;
            for (int k = 0; k < 256; k++)
               if (model_valid[k] && short_age && model_old[k])
               begin
                  model_valid[k] = 1'b0;
                  last = k;                          // sweep runs upward
               end
            exp_prog = (last == 255);   // flag drops at the last index unless it is cleared
            if (!aborted && (last >= 0))
            begin
               check_mac(name, model_mac[last], lst_inv_addr);
               check_fwd(name, model_port[last], exp_prog, lst_inv_port, inval_in_prog);
            end
         end
         default:
         begin
            run_sweep(cmd_inval_all, name);
            foreach (model_valid[k])
               model_valid[k] = 1'b0;
         end
      endcase
   endtask

   function automatic void load_rows();
      add_row(op_frame, mac_a, mac_e, 1'b0);   // unknown destination floods
      add_row(op_frame, mac_b, mac_a, 1'b1);
      add_row(op_frame, mac_c, mac_b, 1'b1);
      add_row(op_frame, mac_d, mac_e, 1'b0);
      add_row(op_frame, mac_h, mac_d, 1'b1);   // fills the last table index
      add_row(op_time, '0, '0, 1'b0);
      add_row(op_age_short, '0, '0, 1'b0);
      add_row(op_frame, mac_f, mac_a, 1'b0);   // learned but aged
      add_row(op_frame, mac_f, mac_c, 1'b0);
      add_row(op_age_short, '0, '0, 1'b0);
      add_row(op_inval_aged, '0, '0, 1'b0);
      add_row(op_age_long, '0, '0, 1'b0);
      add_row(op_frame, mac_g, mac_a, 1'b0);   // cleared by the aged sweep
      add_row(op_frame, mac_a, mac_c, 1'b0);
      add_row(op_frame, mac_b, mac_g, 1'b1);
      add_row(op_frame, mac_c, mac_a, 1'b1);
      add_row(op_inval_all, '0, '0, 1'b0);
      add_row(op_frame, mac_e, mac_g, 1'b0);
      add_row(op_frame, mac_e, mac_b, 1'b0);
      add_row(op_frame, mac_e, mac_a, 1'b0);
      add_row(op_frame, mac_d, mac_c, 1'b0);
      add_row(op_frame, mac_f, mac_e, 1'b1);   // table still learns after clearing
   endfunction

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      void'($urandom(9375));
      n_p_reset20  = 1'b0;
      command      = cmd_none;
      div_clk      = 8'd3;
      best_bfr_age = age_long;
      frame_valid  = 1'b0;
      src_mac      = '0;
      src_port     = '0;
      dst_mac      = '0;
      value_errs   = 0;
      other_errs   = 0;
      aborted      = 1'b0;
      short_age    = 1'b0;
      load_rows();
      repeat (5) @(posedge pclk20);
      n_p_reset20 <= 1'b1;
      @(negedge pclk20);
      check_mac("reset lst_inv_addr", '0, lst_inv_addr);
      check_fwd("reset lst_inv_port", '0, 1'b0, lst_inv_port, inval_in_prog);
      check_fwd("reset fwd_valid", '0, 1'b0, fwd_port, fwd_valid);
      check_fwd("reset age_check_active", '0, 1'b0, fwd_port, age_check_active);
      for (int i = 0; i < rows.size(); i++)
      begin
         apply_row(rows[i], i);
         if (aborted)
            break;
      end
      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
      if ((value_errs == 0) && (other_errs == 0))
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== design/alut_top.sv ====
// alut top level, address checker and age checker sharing the table through the arbiter
module alut_top
   import alut_pkg::*;
(
   input  logic              pclk20,
   input  logic              n_p_reset20,
   input  age_cmd_e          command,
   input  logic [7:0]        div_clk,
   input  logic [time_w-1:0] best_bfr_age,
   input  logic              frame_valid,
   input  logic [mac_w-1:0]  src_mac,
   input  logic [port_w-1:0] src_port,
   input  logic [mac_w-1:0]  dst_mac,
   output logic              fwd_valid,
   output logic [port_w-1:0] fwd_port,
   output logic              fwd_broadcast,
   output logic [time_w-1:0] curr_time,
   output logic [mac_w-1:0]  lst_inv_addr,
   output logic [port_w-1:0] lst_inv_port,
   output logic              inval_in_prog,
   output logic              age_check_active
);

   logic              add_req;
   logic              add_check_active;
   logic              sweep_busy;
   logic              check_age;
   logic              age_confirmed;
   logic              age_ok;
   logic [time_w-1:0] last_accessed;

   alut_mem_if add_bus ();   // address checker side
   alut_mem_if age_bus ();   // age checker side
   alut_mem_if mem_bus ();   // granted port to the table

   alut_addr_checker addr_checker_inst (
      .pclk20, .n_p_reset20, .frame_valid, .src_mac, .src_port, .dst_mac,
      .add_check_active, .age_confirmed, .age_ok, .curr_time, .add_req, .check_age,
      .last_accessed, .fwd_valid, .fwd_port, .fwd_broadcast, .bus(add_bus.requester));

   alut_age_checker age_checker_inst (
      .pclk20, .n_p_reset20, .command, .div_clk, .check_age, .last_accessed,
      .best_bfr_age, .add_check_active, .curr_time, .age_confirmed, .age_ok,
      .lst_inv_addr, .lst_inv_port, .inval_in_prog, .age_check_active, .sweep_busy,
      .bus(age_bus.requester));

   alut_mem_arbiter mem_arbiter_inst (
      .pclk20, .n_p_reset20, .add_req, .sweep_busy, .add_check_active,
      .add_bus(add_bus.arb), .age_bus(age_bus.arb), .mem_bus(mem_bus.requester));

   alut_mem mem_inst (.pclk20, .n_p_reset20, .bus(mem_bus.memory));

endmodule

// ==== design/alut_age_checker.sv ====
// alut age checker, keeps the time counter, answers age queries and runs invalidation sweeps
module alut_age_checker
   import alut_pkg::*;
(
   input  logic              pclk20,
   input  logic              n_p_reset20,
   input  age_cmd_e          command,
   input  logic [7:0]        div_clk,           // time counter divider
   input  logic              check_age,         // query from the address checker
   input  logic [time_w-1:0] last_accessed,
   input  logic [time_w-1:0] best_bfr_age,
   input  logic              add_check_active,
   output logic [time_w-1:0] curr_time,
   output logic              age_confirmed,
   output logic              age_ok,            // set means in date
   output logic [mac_w-1:0]  lst_inv_addr,
   output logic [port_w-1:0] lst_inv_port,
   output logic              inval_in_prog,
   output logic              age_check_active,
   output logic              sweep_busy,
   alut_mem_if.requester     bus
);

   age_state_e        state;
   age_state_e        nxt_state;
   logic [7:0]        clk_div_cnt;
   logic [addr_w-1:0] sweep_addr;       // index under sweep
   age_cmd_e          cmd_q;            // last command seen
   age_cmd_e          cmd_pend;         // sweep waiting to start
   logic              sweep_start;
   logic [time_w-1:0] acc_time_age;     // time read back from the table
   logic [time_w-1:0] elapsed_add;
   logic [time_w-1:0] elapsed_age;
   logic              in_date;

   // elapsed time with the counter wrap taken into account
   function automatic logic [time_w-1:0] elapsed(input logic [time_w-1:0] now,
                                                 input logic [time_w-1:0] last);
      return (now > last) ? (now - last) : (now + (max_cnt - last));
   endfunction

   // ------------------------------------------------------------------------
   // current time counter
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         clk_div_cnt <= '0;
         curr_time   <= '0;
      end
      else if (clk_div_cnt == div_clk)
      begin
         clk_div_cnt <= '0;
         curr_time   <= curr_time + 1'b1;   // one tick per div_clk+1 cycles
      end
      else
         clk_div_cnt <= clk_div_cnt + 1'b1;
   end

   // a new sweep command is held until the table is free
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         cmd_q    <= cmd_none;
         cmd_pend <= cmd_none;
      end
      else
      begin
         cmd_q <= command;
         if (sweep_start)
            cmd_pend <= cmd_none;
         else if ((command != cmd_q) &&
                  ((command == cmd_inval_aged) || (command == cmd_inval_all)))
            cmd_pend <= command;
      end
   end

   assign sweep_start = (state == age_idle) && (cmd_pend != cmd_none) && !add_check_active;

   // ------------------------------------------------------------------------
   // age checker FSM
   // ------------------------------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         age_idle:
            if (sweep_start)
               nxt_state = (cmd_pend == cmd_inval_all) ? age_inval_all : age_inval_rd;
            else if (check_age)
               nxt_state = age_chk;
         age_inval_rd:
            nxt_state = age_chk;
         age_inval_wr:
            nxt_state = (sweep_addr == max_addr) ? age_idle : age_inval_rd;
         age_inval_all:
            if (sweep_addr == '0)             // index 0 is the last one cleared
               nxt_state = age_idle;
         age_chk:
            if (age_confirmed)
            begin
               if (add_check_active)
                  nxt_state = age_idle;       // answer given to the address checker
               else if (bus.rdata[valid_bit] && !age_ok)
                  nxt_state = age_inval_wr;   // valid and out of date
               else if (sweep_addr == max_addr)
                  nxt_state = age_idle;
               else
                  nxt_state = age_inval_rd;
            end
         default:
            nxt_state = age_idle;
      endcase
   end

   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
         state <= age_idle;
      else
         state <= nxt_state;
   end

   // sweep index, all starts at 1 and wraps round to 0
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
         sweep_addr <= '0;
      else if (sweep_start)
         sweep_addr <= (cmd_pend == cmd_inval_all) ? addr_w'(1) : '0;
      else if ((state == age_inval_all) || (nxt_state == age_inval_rd))
         sweep_addr <= sweep_addr + 1'b1;
   end

   assign bus.addr  = sweep_addr;
   assign bus.write = (state == age_inval_wr) || (state == age_inval_all);
   assign bus.wdata = '0;                     // only ever clears entries

   // ------------------------------------------------------------------------
   // age compare
   // ------------------------------------------------------------------------
   assign acc_time_age = bus.rdata[time_msb:time_lsb];
   assign elapsed_add  = elapsed(curr_time, last_accessed);
   assign elapsed_age  = elapsed(curr_time, acc_time_age);
   assign in_date      = add_check_active ? (best_bfr_age > elapsed_add)
                                          : (best_bfr_age > elapsed_age);

   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else if ((state == age_chk) && !age_confirmed)
      begin
         age_confirmed <= 1'b1;               // one cycle answer
         age_ok        <= in_date;
      end
      else
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
   end

   // last cleared entry and the aged flag
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         lst_inv_addr  <= '0;
         lst_inv_port  <= '0;
         inval_in_prog <= 1'b0;
      end
      else if (state == age_inval_wr)
      begin
         lst_inv_addr  <= bus.rdata[mac_w-1:0];   // entry read in age_chk
         lst_inv_port  <= bus.rdata[port_msb:port_lsb];
         inval_in_prog <= 1'b1;
      end
      else if ((state == age_chk) && !add_check_active && (sweep_addr == max_addr))
         inval_in_prog <= 1'b0;                   // sweep reached the last index
   end

   assign age_check_active = (state != age_idle);
   assign sweep_busy = (state == age_inval_rd) || (state == age_inval_wr) ||
                       (state == age_inval_all) ||
                       ((state == age_chk) && !add_check_active) || sweep_start;

   // a query is answered two cycles after it is asked
   a_confirm_after_chk: assert property (@(posedge pclk20) disable iff (!n_p_reset20)
      check_age |-> ##2 age_confirmed);

endmodule

// ==== design/alut_addr_checker.sv ====
// alut address checker, looks up the destination of a frame and learns its source
module alut_addr_checker
   import alut_pkg::*;
(
   input  logic              pclk20,
   input  logic              n_p_reset20,
   input  logic              frame_valid,       // frame strobe, taken only in idle
   input  logic [mac_w-1:0]  src_mac,
   input  logic [port_w-1:0] src_port,
   input  logic [mac_w-1:0]  dst_mac,
   input  logic              add_check_active,  // table granted
   input  logic              age_confirmed,     // age_ok is valid
   input  logic              age_ok,            // entry in date
   input  logic [time_w-1:0] curr_time,
   output logic              add_req,
   output logic              check_age,         // one cycle age query
   output logic [time_w-1:0] last_accessed,
   output logic              fwd_valid,
   output logic [port_w-1:0] fwd_port,
   output logic              fwd_broadcast,
   alut_mem_if.requester     bus
);

   addr_state_e       state;
   logic [mac_w-1:0]  src_q;          // latched frame
   logic [mac_w-1:0]  dst_q;
   logic [port_w-1:0] src_port_q;
   logic [port_w-1:0] dst_port_q;     // port stored for the destination
   alut_entry_t       rd_entry;
   alut_entry_t       learn_entry;
   logic              hit;

   assign rd_entry    = alut_entry_t'(bus.rdata);
   assign hit         = rd_entry.valid && (rd_entry.mac == dst_q);
   assign learn_entry = '{valid: 1'b1, last_time: curr_time, port: src_port_q, mac: src_q};

   // frame capture
   always_ff @(posedge pclk20)
   begin
      if ((state == addr_idle) && frame_valid)
      begin
         src_q      <= src_mac;
         dst_q      <= dst_mac;
         src_port_q <= src_port;
      end
   end

   // ------------------------------------------------------------------------
   // lookup and learn FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         state         <= addr_idle;
         check_age     <= 1'b0;
         last_accessed <= '0;
         dst_port_q    <= '0;
         fwd_valid     <= 1'b0;
         fwd_port      <= '0;
         fwd_broadcast <= 1'b0;
      end
      else
      begin
         check_age <= 1'b0;                  // pulses
         fwd_valid <= 1'b0;
         case (state)
            addr_idle:
               if (frame_valid)
                  state <= addr_req;
            addr_req:
               if (add_check_active)         // wait for the table
                  state <= addr_rd;
            addr_rd:
               state <= addr_wait_rd;         // destination index on the bus
            addr_wait_rd:
               if (hit)
               begin
                  state         <= addr_age;
                  check_age     <= 1'b1;
                  last_accessed <= rd_entry.last_time;
                  dst_port_q    <= rd_entry.port;
               end
               else
               begin
                  // unknown destination, flood it
                  state         <= addr_learn;
                  fwd_valid     <= 1'b1;
                  fwd_port      <= '0;
                  fwd_broadcast <= 1'b1;
               end
            addr_age:
               if (age_confirmed)
               begin
                  state         <= addr_learn;
                  fwd_valid     <= 1'b1;
                  fwd_port      <= age_ok ? dst_port_q : '0;
                  fwd_broadcast <= !age_ok;  // aged entry floods too
               end
            addr_learn:
               state <= addr_idle;            // source written this cycle
            default:
               state <= addr_idle;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // memory requests
   // ------------------------------------------------------------------------
   assign add_req   = (state != addr_idle);  // held through the learn write
   assign bus.write = (state == addr_learn);
   assign bus.addr  = (state == addr_learn) ? hash_mac(src_q) : hash_mac(dst_q);
   assign bus.wdata = learn_entry;

   // one cycle query, asked only while the table is held
   a_check_age_pulse: assert property (@(posedge pclk20) disable iff (!n_p_reset20)
      check_age |-> add_check_active ##1 !check_age);

endmodule

// ==== design/alut_mem_arbiter.sv ====
// alut memory arbiter, hands the table to the address checker or the age checker
module alut_mem_arbiter
(
   input  logic          pclk20,
   input  logic          n_p_reset20,
   input  logic          add_req,            // level from the address checker
   input  logic          sweep_busy,         // age checker owns the table
   output logic          add_check_active,   // address checker owns the table
   alut_mem_if.arb       add_bus,
   alut_mem_if.arb       age_bus,
   alut_mem_if.requester mem_bus
);

   // ------------------------------------------------------------------------
   // ownership flop
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
         add_check_active <= 1'b0;
      else if (!add_req)
         add_check_active <= 1'b0;       // released as soon as the request drops
      else if (!sweep_busy)
         add_check_active <= 1'b1;       // granted only between sweeps, then held
   end

   // ------------------------------------------------------------------------
   // bus mux
   // ------------------------------------------------------------------------
   assign mem_bus.addr  = add_check_active ? add_bus.addr  : age_bus.addr;
   assign mem_bus.write = add_check_active ? add_bus.write : age_bus.write;
   assign mem_bus.wdata = add_check_active ? add_bus.wdata : age_bus.wdata;

   assign add_bus.rdata = mem_bus.rdata;   // both sides see the read data
   assign age_bus.rdata = mem_bus.rdata;

   // a grant in the middle of a sweep would split its read and write
   a_no_grant_in_sweep: assert property (@(posedge pclk20) disable iff (!n_p_reset20)
      add_check_active |-> !sweep_busy);

endmodule

// ==== design/alut_mem.sv ====
// alut table memory, 256 entries of 83 bits with one synchronous read/write port
module alut_mem
   import alut_pkg::*;
(
   input  logic      pclk20,
   input  logic      n_p_reset20,
   alut_mem_if.memory bus
);

   logic [entry_w-1:0] ram [2**addr_w];   // the address table

   always_ff @(posedge pclk20)
   begin
      if (bus.write)
         ram[bus.addr] <= bus.wdata;
      bus.rdata <= ram[bus.addr];          // read returns the old word on a write
   end

   // a write to an unknown index would corrupt an unknown entry
   a_wr_addr_known: assert property (@(posedge pclk20) disable iff (!n_p_reset20)
      bus.write |-> !$isunknown(bus.addr));

endmodule

// ==== design/alut_mem_if.sv ====
// alut memory port, one address with a write strobe and a registered read
interface alut_mem_if import alut_pkg::*; ();

   logic [addr_w-1:0]  addr;    // table index
   logic               write;   // high for a write cycle
   logic [entry_w-1:0] wdata;
   logic [entry_w-1:0] rdata;   // valid one cycle after addr

   modport requester (output addr, output write, output wdata, input rdata);

   modport memory (input addr, input write, input wdata, output rdata);

   // arbiter side of a requester, it samples the request and returns rdata
   modport arb (input addr, input write, input wdata, output rdata);

endinterface

// ==== design/alut_pkg.sv ====
// alut package with the table entry layout, constants, FSM and command types and the index hash
package alut_pkg;

   // ------------------------------------------------------------------------
   // entry layout
   // ------------------------------------------------------------------------
   localparam int entry_w   = 83;   // valid + time + port + mac
   localparam int valid_bit = 82;
   localparam int time_lsb  = 50;
   localparam int time_msb  = 81;
   localparam int port_lsb  = 48;
   localparam int port_msb  = 49;
   localparam int mac_w     = 48;
   localparam int time_w    = 32;
   localparam int addr_w    = 8;    // table index, 256 entries
   localparam int port_w    = 2;

   localparam logic [addr_w-1:0] max_addr = 8'hff;         // last table index
   localparam logic [time_w-1:0] max_cnt  = 32'hffff_ffff; // time counter wrap value

   typedef struct packed
   {
      logic              valid;
      logic [time_w-1:0] last_time;   // time of last access
      logic [port_w-1:0] port;
      logic [mac_w-1:0]  mac;
   } alut_entry_t;

   typedef enum logic [1:0] {cmd_none = 2'd0, cmd_rsvd = 2'd1,
                             cmd_inval_aged = 2'd2, cmd_inval_all = 2'd3} age_cmd_e;

   typedef enum logic [2:0] {age_idle, age_inval_rd, age_inval_wr,
                             age_inval_all, age_chk} age_state_e;

   typedef enum logic [2:0] {addr_idle, addr_req, addr_rd, addr_wait_rd,
                             addr_age, addr_learn} addr_state_e;

   // table index of a mac, xor of its six bytes
   function automatic logic [addr_w-1:0] hash_mac(input logic [mac_w-1:0] mac);
      logic [addr_w-1:0] idx;
      idx = '0;
      for (int i = 0; i < mac_w / addr_w; i++)
         idx ^= mac[i*addr_w +: addr_w];
      return idx;
   endfunction

endpackage
